//--- hdl/host_link_pkg.sv
package host_link_pkg;

	// Host FIFO word and core word widths
	localparam int HOST_W = 16;
	localparam int CORE_W = 32;

	// Defaults for the top level parameters
	localparam int DEF_NUM_CORES = 8;
	localparam int DEF_HALT_PC = 4;
	localparam int DEF_SETTLE_CYCLES = 20;
	localparam int DEF_READ_WAIT = 5;
	localparam int DEF_START_HOLD = 30;

	// Frame start and command type words
	localparam logic [HOST_W-1:0] FLAG_START = 16'hFFF0;
	localparam logic [HOST_W-1:0] CMD_WRITE = 16'hFFF1;
	localparam logic [HOST_W-1:0] CMD_READ = 16'hFFF2;
	localparam logic [HOST_W-1:0] CMD_START = 16'hFFF3;

	typedef enum logic [4:0] {
		ST_IDLE,
		ST_SETTLE,
		ST_FLAG_DLY,
		ST_FLAG,
		ST_ID_DLY,
		ST_ID,
		ST_CORE_WAIT,
		ST_TYPE_DLY,
		ST_TYPE,
		ST_ADDR_DLY,
		ST_ADDR,
		ST_SIZE_DLY,
		ST_SIZE,
		ST_WR_NEXT,
		ST_WR_HI_DLY,
		ST_WR_HI,
		ST_WR_LO_DLY,
		ST_WR_LO,
		ST_RD_WAIT,
		ST_RD_HI,
		ST_RD_LO,
		ST_RD_NEXT,
		ST_RESET,
		ST_START,
		ST_CLEAN,
		ST_CLEAN_DLY
	} cmd_state_t;

endpackage

//--- hdl/host_cmd_fsm.sv
module host_cmd_fsm #(
	parameter int SETTLE_CYCLES = host_link_pkg::DEF_SETTLE_CYCLES,
	parameter int READ_WAIT = host_link_pkg::DEF_READ_WAIT,
	parameter int START_HOLD = host_link_pkg::DEF_START_HOLD
) (
	input  logic                             SDK_CLK,
	input  logic                             SDK_RSTN,
	input  logic                             fifo_empty_i,
	input  logic                             fifo_full_i,
	input  logic [host_link_pkg::HOST_W-1:0] fifo_data_i,
	input  logic                             sel_stalled_i,
	input  logic                             more_words_i,
	input  logic                             delay_done_i,
	input  logic [host_link_pkg::CORE_W-1:0] ram_data_i,
	output logic                             fifo_rd_o,
	output logic                             fifo_wr_o,
	output logic [host_link_pkg::HOST_W-1:0] fifo_data_o,
	output logic                             latch_id_o,
	output logic                             latch_addr_o,
	output logic                             latch_size_o,
	output logic                             latch_hi_o,
	output logic                             latch_lo_o,
	output logic                             cnt_step_o,
	output logic                             delay_en_o,
	output logic [host_link_pkg::HOST_W-1:0] delay_limit_o,
	output logic                             clean_o,
	output logic                             ram_write_o,
	output logic                             core_reset_o,
	output logic                             core_start_o
);
	import host_link_pkg::*;

	cmd_state_t state_q;
	cmd_state_t state_d;
	logic [HOST_W-1:0] type_q;
	logic latch_type;
	logic rd_d;
	logic wr_d;
	logic [HOST_W-1:0] wr_data_d;

	always_comb begin
		state_d = state_q;
		rd_d = 1'b0;
		wr_d = 1'b0;
		wr_data_d = '0;
		latch_type = 1'b0;
		latch_id_o = 1'b0;
		latch_addr_o = 1'b0;
		latch_size_o = 1'b0;
		latch_hi_o = 1'b0;
		latch_lo_o = 1'b0;
		cnt_step_o = 1'b0;
		delay_en_o = 1'b0;
		clean_o = 1'b0;
		ram_write_o = 1'b0;
		core_reset_o = 1'b0;
		core_start_o = 1'b0;
		case (state_q)
			ST_IDLE: begin
				if (!fifo_empty_i) begin
					state_d = ST_SETTLE;
				end
			end
			// Give the host time to finish pushing the frame
			ST_SETTLE: begin
				delay_en_o = 1'b1;
				if (delay_done_i) begin
					rd_d = 1'b1;
					state_d = ST_FLAG_DLY;
				end
			end
			ST_FLAG_DLY: state_d = ST_FLAG;
			ST_FLAG: begin
				if (fifo_data_i == FLAG_START) begin
					rd_d = 1'b1;
					state_d = ST_ID_DLY;
				end else begin
					state_d = ST_IDLE;
				end
			end
			ST_ID_DLY: state_d = ST_ID;
			ST_ID: begin
				latch_id_o = 1'b1;
				state_d = ST_CORE_WAIT;
			end
			ST_CORE_WAIT: begin
				if (sel_stalled_i) begin
					rd_d = 1'b1;
					state_d = ST_TYPE_DLY;
				end
			end
			ST_TYPE_DLY: state_d = ST_TYPE;
			ST_TYPE: begin
				latch_type = 1'b1;
				case (fifo_data_i)
					CMD_WRITE, CMD_READ: begin
						rd_d = 1'b1;
						state_d = ST_ADDR_DLY;
					end
					CMD_START: state_d = ST_RESET;
					default: state_d = ST_CLEAN;
				endcase
			end
			ST_ADDR_DLY: state_d = ST_ADDR;
			ST_ADDR: begin
				latch_addr_o = 1'b1;
				rd_d = 1'b1;
				state_d = ST_SIZE_DLY;
			end
			ST_SIZE_DLY: state_d = ST_SIZE;
			ST_SIZE: begin
				latch_size_o = 1'b1;
				if (type_q == CMD_WRITE) begin
					state_d = ST_WR_NEXT;
				end else begin
					state_d = ST_RD_WAIT;
				end
			end
			// Fetch the high half of the next word
			ST_WR_NEXT: begin
				if (!more_words_i) begin
					state_d = ST_CLEAN;
				end else if (!fifo_empty_i) begin
					rd_d = 1'b1;
					state_d = ST_WR_HI_DLY;
				end
			end
			ST_WR_HI_DLY: state_d = ST_WR_HI;
			ST_WR_HI: begin
				if (!fifo_empty_i) begin
					latch_hi_o = 1'b1;
					cnt_step_o = 1'b1;
					rd_d = 1'b1;
					state_d = ST_WR_LO_DLY;
				end
			end
			ST_WR_LO_DLY: state_d = ST_WR_LO;
			ST_WR_LO: begin
				latch_lo_o = 1'b1;
				cnt_step_o = 1'b1;
				ram_write_o = 1'b1;
				state_d = ST_WR_NEXT;
			end
			// RAM read latency
			ST_RD_WAIT: begin
				delay_en_o = 1'b1;
				if (delay_done_i) begin
					state_d = ST_RD_HI;
				end
			end
			ST_RD_HI: begin
				if (!fifo_full_i) begin
					wr_d = 1'b1;
					wr_data_d = ram_data_i[CORE_W-1:HOST_W];
					cnt_step_o = 1'b1;
					state_d = ST_RD_LO;
				end
			end
			ST_RD_LO: begin
				if (!fifo_full_i) begin
					wr_d = 1'b1;
					wr_data_d = ram_data_i[HOST_W-1:0];
					cnt_step_o = 1'b1;
					state_d = ST_RD_NEXT;
				end
			end
			ST_RD_NEXT: state_d = more_words_i ? ST_RD_WAIT : ST_CLEAN;
			ST_RESET: begin
				core_reset_o = 1'b1;
				state_d = ST_START;
			end
			ST_START: begin
				delay_en_o = 1'b1;
				core_start_o = 1'b1;
				if (delay_done_i) begin
					state_d = ST_CLEAN;
				end
			end
			ST_CLEAN: begin
				clean_o = 1'b1;
				state_d = ST_CLEAN_DLY;
			end
			ST_CLEAN_DLY: state_d = ST_IDLE;
			default: state_d = ST_IDLE;
		endcase
	end

	// Delay limit for the states that count
	always_comb begin
		case (state_q)
			ST_SETTLE: delay_limit_o = HOST_W'(SETTLE_CYCLES);
			ST_RD_WAIT: delay_limit_o = HOST_W'(READ_WAIT);
			ST_START: delay_limit_o = HOST_W'(START_HOLD);
			default: delay_limit_o = '0;
		endcase
	end

	always_ff @(posedge SDK_CLK or negedge SDK_RSTN) begin
		if (!SDK_RSTN) begin
			state_q <= ST_IDLE;
			fifo_rd_o <= 1'b0;
			fifo_wr_o <= 1'b0;
			fifo_data_o <= '0;
		end else begin
			state_q <= state_d;
			fifo_rd_o <= rd_d;
			fifo_wr_o <= wr_d;
			fifo_data_o <= wr_data_d;
		end
	end

	always_ff @(posedge SDK_CLK or negedge SDK_RSTN) begin
		if (!SDK_RSTN) begin
			type_q <= '0;
		end else if (clean_o) begin
			type_q <= '0;
		end else if (latch_type) begin
			type_q <= fifo_data_i;
		end
	end

endmodule

//--- hdl/ram_xfer_path.sv
module ram_xfer_path (
	input  logic                             SDK_CLK,
	input  logic                             SDK_RSTN,
	input  logic [host_link_pkg::HOST_W-1:0] fifo_data_i,
	input  logic                             latch_addr_i,
	input  logic                             latch_size_i,
	input  logic                             latch_hi_i,
	input  logic                             latch_lo_i,
	input  logic                             cnt_step_i,
	input  logic                             delay_en_i,
	input  logic [host_link_pkg::HOST_W-1:0] delay_limit_i,
	input  logic                             clean_i,
	output logic                             more_words_o,
	output logic                             delay_done_o,
	output logic [host_link_pkg::HOST_W-1:0] ram_addr_o,
	output logic [host_link_pkg::CORE_W-1:0] ram_data_o
);
	import host_link_pkg::*;

	logic [HOST_W-1:0] addr_q;
	logic [HOST_W-1:0] size_q;
	logic [HOST_W-1:0] byte_cnt;
	logic [HOST_W-1:0] delay_cnt;
	logic [HOST_W-1:0] hi_q;
	logic [HOST_W-1:0] lo_q;

	// Base address and byte size of the block
	always_ff @(posedge SDK_CLK or negedge SDK_RSTN) begin
		if (!SDK_RSTN) begin
			addr_q <= '0;
			size_q <= '0;
		end else begin
			if (latch_addr_i) begin
				addr_q <= fifo_data_i;
			end
			if (latch_size_i) begin
				size_q <= fifo_data_i;
			end
		end
	end

	always_ff @(posedge SDK_CLK) begin
		if (latch_hi_i) begin
			hi_q <= fifo_data_i;
		end
		if (latch_lo_i) begin
			lo_q <= fifo_data_i;
		end
	end

	assign ram_data_o = {hi_q, lo_q};

	// One step per 16-bit half
	always_ff @(posedge SDK_CLK or negedge SDK_RSTN) begin
		if (!SDK_RSTN) begin
			byte_cnt <= '0;
		end else if (clean_i) begin
			byte_cnt <= '0;
		end else if (cnt_step_i) begin
			byte_cnt <= byte_cnt + HOST_W'(2);
		end
	end

	always_ff @(posedge SDK_CLK or negedge SDK_RSTN) begin
		if (!SDK_RSTN) begin
			delay_cnt <= '0;
		end else if (delay_en_i) begin
			delay_cnt <= delay_cnt + HOST_W'(1);
		end else begin
			delay_cnt <= '0;
		end
	end

	// Word address follows the byte count
	always_ff @(posedge SDK_CLK or negedge SDK_RSTN) begin
		if (!SDK_RSTN) begin
			ram_addr_o <= '0;
		end else begin
			ram_addr_o <= addr_q + {2'b00, byte_cnt[HOST_W-1:2]};
		end
	end

	assign more_words_o = (byte_cnt < size_q);
	assign delay_done_o = (delay_cnt > delay_limit_i);

endmodule

//--- hdl/core_ctrl.sv
module core_ctrl #(
	parameter int NUM_CORES = host_link_pkg::DEF_NUM_CORES,
	parameter int HALT_PC = host_link_pkg::DEF_HALT_PC
) (
	input  logic                                       SDK_CLK,
	input  logic                                       SDK_RSTN,
	input  logic [host_link_pkg::HOST_W-1:0]           fifo_data_i,
	input  logic                                       latch_id_i,
	input  logic                                       clean_i,
	input  logic                                       ram_write_i,
	input  logic                                       core_reset_i,
	input  logic                                       core_start_i,
	input  logic [NUM_CORES*host_link_pkg::CORE_W-1:0] core_pc_i,
	output logic [host_link_pkg::HOST_W-1:0]           core_id_o,
	output logic                                       sel_stalled_o,
	output logic [NUM_CORES-1:0]                       core_rstn_o,
	output logic [NUM_CORES-1:0]                       core_stall_o,
	output logic [NUM_CORES-1:0]                       ram_we_o
);
	import host_link_pkg::*;

	logic [HOST_W-1:0] id_q;
	logic [NUM_CORES-1:0] sel_hot;
	logic [NUM_CORES-1:0] halted;
	logic [NUM_CORES-1:0] stall_d;

	always_ff @(posedge SDK_CLK or negedge SDK_RSTN) begin
		if (!SDK_RSTN) begin
			id_q <= '0;
		end else if (clean_i) begin
			id_q <= '0;
		end else if (latch_id_i) begin
			id_q <= fifo_data_i;
		end
	end

	assign core_id_o = id_q;

	always_comb begin
		for (int i = 0; i < NUM_CORES; i++) begin
			sel_hot[i] = (id_q == HOST_W'(i));
			halted[i] = (core_pc_i[i*CORE_W +: CORE_W] == CORE_W'(HALT_PC));
		end
	end

	// An id with no core behind it counts as stalled so the frame still drains
	assign sel_stalled_o = ~|sel_hot | |(sel_hot & core_stall_o);

	// Start of the selected core wins over its halt address
	assign stall_d = (core_stall_o | halted) & ~(sel_hot & {NUM_CORES{core_start_i}});

	always_ff @(posedge SDK_CLK or negedge SDK_RSTN) begin
		if (!SDK_RSTN) begin
			core_stall_o <= '1;
			core_rstn_o <= '1;
			ram_we_o <= '0;
		end else begin
			core_stall_o <= stall_d;
			core_rstn_o <= ~(sel_hot & {NUM_CORES{core_reset_i}});
			ram_we_o <= sel_hot & {NUM_CORES{ram_write_i}};
		end
	end

endmodule

//--- hdl/host_link_top.sv
module host_link_top #(
	parameter int NUM_CORES = host_link_pkg::DEF_NUM_CORES,
	parameter int HALT_PC = host_link_pkg::DEF_HALT_PC,
	parameter int SETTLE_CYCLES = host_link_pkg::DEF_SETTLE_CYCLES,
	parameter int READ_WAIT = host_link_pkg::DEF_READ_WAIT,
	parameter int START_HOLD = host_link_pkg::DEF_START_HOLD
) (
	input  logic                                       SDK_CLK,
	input  logic                                       SDK_RSTN,
	output logic                                       fifo_rd_o,
	input  logic [host_link_pkg::HOST_W-1:0]           fifo_data_i,
	input  logic                                       fifo_empty_i,
	output logic                                       fifo_wr_o,
	output logic [host_link_pkg::HOST_W-1:0]           fifo_data_o,
	input  logic                                       fifo_full_i,
	output logic [NUM_CORES-1:0]                       core_rstn_o,
	output logic [NUM_CORES-1:0]                       core_stall_o,
	output logic [NUM_CORES-1:0]                       ram_we_o,
	output logic [host_link_pkg::HOST_W-1:0]           ram_addr_o,
	output logic [host_link_pkg::CORE_W-1:0]           ram_data_o,
	input  logic [host_link_pkg::CORE_W-1:0]           ram_data_i,
	input  logic [NUM_CORES*host_link_pkg::CORE_W-1:0] core_pc_i,
	output logic [host_link_pkg::HOST_W-1:0]           core_id_o
);
	import host_link_pkg::*;

	logic latch_id;
	logic latch_addr;
	logic latch_size;
	logic latch_hi;
	logic latch_lo;
	logic cnt_step;
	logic delay_en;
	logic [HOST_W-1:0] delay_limit;
	logic clean;
	logic ram_write;
	logic core_reset;
	logic core_start;
	logic more_words;
	logic delay_done;
	logic sel_stalled;

	host_cmd_fsm #(
		.SETTLE_CYCLES(SETTLE_CYCLES),
		.READ_WAIT(READ_WAIT),
		.START_HOLD(START_HOLD)
	) host_cmd_fsm_inst (
		.SDK_CLK(SDK_CLK),
		.SDK_RSTN(SDK_RSTN),
		.fifo_empty_i(fifo_empty_i),
		.fifo_full_i(fifo_full_i),
		.fifo_data_i(fifo_data_i),
		.sel_stalled_i(sel_stalled),
		.more_words_i(more_words),
		.delay_done_i(delay_done),
		.ram_data_i(ram_data_i),
		.fifo_rd_o(fifo_rd_o),
		.fifo_wr_o(fifo_wr_o),
		.fifo_data_o(fifo_data_o),
		.latch_id_o(latch_id),
		.latch_addr_o(latch_addr),
		.latch_size_o(latch_size),
		.latch_hi_o(latch_hi),
		.latch_lo_o(latch_lo),
		.cnt_step_o(cnt_step),
		.delay_en_o(delay_en),
		.delay_limit_o(delay_limit),
		.clean_o(clean),
		.ram_write_o(ram_write),
		.core_reset_o(core_reset),
		.core_start_o(core_start)
	);

	ram_xfer_path ram_xfer_path_inst (
		.SDK_CLK(SDK_CLK),
		.SDK_RSTN(SDK_RSTN),
		.fifo_data_i(fifo_data_i),
		.latch_addr_i(latch_addr),
		.latch_size_i(latch_size),
		.latch_hi_i(latch_hi),
		.latch_lo_i(latch_lo),
		.cnt_step_i(cnt_step),
		.delay_en_i(delay_en),
		.delay_limit_i(delay_limit),
		.clean_i(clean),
		.more_words_o(more_words),
		.delay_done_o(delay_done),
		.ram_addr_o(ram_addr_o),
		.ram_data_o(ram_data_o)
	);

	core_ctrl #(
		.NUM_CORES(NUM_CORES),
		.HALT_PC(HALT_PC)
	) core_ctrl_inst (
		.SDK_CLK(SDK_CLK),
		.SDK_RSTN(SDK_RSTN),
		.fifo_data_i(fifo_data_i),
		.latch_id_i(latch_id),
		.clean_i(clean),
		.ram_write_i(ram_write),
		.core_reset_i(core_reset),
		.core_start_i(core_start),
		.core_pc_i(core_pc_i),
		.core_id_o(core_id_o),
		.sel_stalled_o(sel_stalled),
		.core_rstn_o(core_rstn_o),
		.core_stall_o(core_stall_o),
		.ram_we_o(ram_we_o)
	);

endmodule

//--- tests/host_link_checker.sv
module host_link_checker #(
	parameter int NUM_CORES = 8,
	parameter int HALT_PC = 4,
	parameter int SETTLE_CYCLES = 20,
	parameter int READ_WAIT = 5,
	parameter int START_HOLD = 30,
	parameter int HOLD_CYCLES = 150
) (
	input  logic                          SDK_CLK,
	input  logic                          SDK_RSTN,
	input  logic                          fifo_rd_i,
	input  logic                          fifo_wr_i,
	input  logic [15:0]                   fifo_data_i,
	input  logic                          fifo_full_i,
	input  logic [NUM_CORES-1:0]          core_rstn_i,
	input  logic [NUM_CORES-1:0]          core_stall_i,
	input  logic [NUM_CORES-1:0]          ram_we_i,
	input  logic [15:0]                   ram_addr_i,
	input  logic [31:0]                   ram_data_i,
	input  logic [NUM_CORES*32-1:0]       core_pc_i,
	input  logic [15:0]                   core_id_i,
	output int                            errors_o,
	output logic                          timeout_o
);
	timeunit 1ns;
	timeprecision 1ns;

	// Seven commands of at most eight words, full stretches up to eight cycles
	localparam int CMD_CYCLES = SETTLE_CYCLES + START_HOLD + 30;
	localparam int WORD_CYCLES = READ_WAIT + 2 * 8 + 8;
	localparam int LIMIT = 2 * (7 * (CMD_CYCLES + 8 * WORD_CYCLES) + HOLD_CYCLES + 20);

	logic [63:0] exp_w[$];
	logic [15:0] exp_rd[$];
	logic [NUM_CORES-1:0] exp_stall = '1;
	logic full_prev = 1'b0;
	int start_core = 0;
	int starts_exp = 0;
	int rstn_lows = 0;
	int err_count = 0;
	int test_base = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycle = 0;

	assign errors_o = err_count;
	initial timeout_o = 1'b0;

	// Write triple is core, word address, data
	function automatic logic [63:0] write_triple(input int core, input int base, input int idx,
			input logic [31:0] data);
		return {16'(core), 16'(base + idx), data};
	endfunction

	function automatic logic [31:0] expected_ram_word(input int core, input logic [15:0] addr);
		return {8'(core), addr ^ 16'hA55A, ~addr[7:0]};
	endfunction

	function automatic logic [NUM_CORES-1:0] next_stall(input logic [NUM_CORES-1:0] prev,
			input logic [NUM_CORES*32-1:0] pc);
		logic [NUM_CORES-1:0] s;
		s = prev;
		for (int i = 0; i < NUM_CORES; i++) begin
			if (pc[i*32 +: 32] == 32'(HALT_PC)) begin
				s[i] = 1'b1;
			end
		end
		return s;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		$display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
		err_count++;
	endtask

	task automatic report_fault(input string msg);
		$display("%s (at %0t)", msg, $time);
		err_count++;
	endtask

	task automatic expect_write(input int core, input int base, input int idx,
			input logic [31:0] d);
		exp_w.push_back(write_triple(core, base, idx, d));
	endtask

	task automatic expect_read(input int core, input int addr);
		logic [31:0] w;
		w = expected_ram_word(core, 16'(addr));
		exp_rd.push_back(w[31:16]);
		exp_rd.push_back(w[15:0]);
	endtask

	task automatic expect_start(input int core);
		start_core = core;
		starts_exp++;
		exp_stall[core] = 1'b0;
	endtask

	task automatic check_reset();
		if (fifo_rd_i || fifo_wr_i || ram_we_i != '0) begin
			report_fault("a strobe or RAM write enable is active after reset");
		end
		if (core_stall_i != '1) begin
			report_mismatch("core_stall_o", 64'(core_stall_i), 64'(exp_stall));
		end
		if (core_rstn_i != '1) begin
			report_mismatch("core_rstn_o", 64'(core_rstn_i), {64{1'b1}} >> (64 - NUM_CORES));
		end
	endtask

	task automatic finish_test(input string name);
		if (exp_w.size() != 0) begin
			report_fault($sformatf("%0d expected RAM writes never happened", exp_w.size()));
		end
		if (exp_rd.size() != 0) begin
			report_fault($sformatf("%0d expected output words never arrived", exp_rd.size()));
		end
		if (rstn_lows != starts_exp) begin
			report_fault($sformatf("saw %0d core reset pulses, wanted %0d", rstn_lows, starts_exp));
		end
		if (core_stall_i != exp_stall) begin
			report_mismatch("core_stall_o", 64'(core_stall_i), 64'(exp_stall));
		end
		tests_run++;
		if (err_count == test_base) begin
			$display("test %s: pass", name);
		end else begin
			$display("test %s: fail with %0d errors", name, err_count - test_base);
			tests_failed++;
		end
		exp_w.delete();
		exp_rd.delete();
		rstn_lows = 0;
		starts_exp = 0;
		test_base = err_count;
	endtask

	task automatic report_counts();
		$display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
			tests_run - tests_failed, tests_failed, err_count);
	endtask

	always @(posedge SDK_CLK) begin
		logic [63:0] e;
		logic [15:0] h;
		logic [NUM_CORES-1:0] hot;
		if (SDK_RSTN) begin
			cycle++;
			if (cycle == LIMIT) begin
				$display("timeout: the run did not finish within %0d cycles", LIMIT);
				timeout_o <= 1'b1;
			end
			exp_stall = next_stall(exp_stall, core_pc_i);
			if (ram_we_i != '0) begin
				if (exp_w.size() == 0) begin
					report_fault("RAM write enable pulsed with no write expected");
				end else begin
					e = exp_w.pop_front();
					hot = '0;
					hot[e[63:48]] = 1'b1;
					if (ram_we_i != hot) begin
						report_mismatch("ram_we_o", 64'(ram_we_i), 64'(hot));
					end
					if (core_id_i != e[63:48]) begin
						report_mismatch("core_id_o", 64'(core_id_i), 64'(e[63:48]));
					end
					if (ram_addr_i != e[47:32]) begin
						report_mismatch("ram_addr_o", 64'(ram_addr_i), 64'(e[47:32]));
					end
					if (ram_data_i != e[31:0]) begin
						report_mismatch("ram_data_o", 64'(ram_data_i), 64'(e[31:0]));
					end
				end
			end
			if (fifo_wr_i) begin
				if (full_prev) begin
					report_fault("output FIFO was written while it was full");
				end
				if (exp_rd.size() == 0) begin
					report_fault("output FIFO written with no read word expected");
				end else begin
					h = exp_rd.pop_front();
					if (fifo_data_i != h) begin
						report_mismatch("fifo_data_o", 64'(fifo_data_i), 64'(h));
					end
				end
			end
			if (core_rstn_i != '1) begin
				hot = '1;
				hot[start_core] = 1'b0;
				if (rstn_lows >= starts_exp) begin
					report_fault("core reset asserted with no start pending");
				end else begin
					if (core_rstn_i != hot) begin
						report_mismatch("core_rstn_o", 64'(core_rstn_i), 64'(hot));
					end
					rstn_lows++;
				end
			end
			full_prev = fifo_full_i;
		end
	end

endmodule

//--- tests/tb_host_link.sv
module tb_host_link;
	timeunit 1ns;
	timeprecision 1ns;
	import host_link_pkg::*;

	localparam int NUM_CORES = DEF_NUM_CORES;
	localparam int HOLD_CYCLES = 150;
	localparam logic [31:0] SEED = 32'd81985;

	logic SDK_CLK = 1'b0;
	logic SDK_RSTN = 1'b0;
	logic fifo_rd_o;
	logic [HOST_W-1:0] fifo_data_i = '0;
	logic fifo_empty_i = 1'b1;
	logic fifo_wr_o;
	logic [HOST_W-1:0] fifo_data_o;
	logic fifo_full_i = 1'b0;
	logic [NUM_CORES-1:0] core_rstn_o;
	logic [NUM_CORES-1:0] core_stall_o;
	logic [NUM_CORES-1:0] ram_we_o;
	logic [HOST_W-1:0] ram_addr_o;
	logic [CORE_W-1:0] ram_data_o;
	logic [CORE_W-1:0] ram_data_i;
	logic [NUM_CORES*CORE_W-1:0] core_pc_i = '0;
	logic [HOST_W-1:0] core_id_o;
	int err_total;
	logic timed_out;

	logic [HOST_W-1:0] in_q[$];
	logic [HOST_W-1:0] frame_q[$];
	logic [HOST_W-1:0] out_q[$];
	logic [31:0] stim_lfsr = SEED;
	logic [31:0] full_lfsr = SEED;
	logic [31:0] full_bits;
	int full_left = 0;
	int we_seen = 0;

	always #10 SDK_CLK = ~SDK_CLK;

	host_link_top host_link_top_inst (.*);

	host_link_checker #(
		.NUM_CORES(NUM_CORES), .HALT_PC(DEF_HALT_PC), .SETTLE_CYCLES(DEF_SETTLE_CYCLES),
		.READ_WAIT(DEF_READ_WAIT), .START_HOLD(DEF_START_HOLD), .HOLD_CYCLES(HOLD_CYCLES)
	) chk (
		.SDK_CLK(SDK_CLK), .SDK_RSTN(SDK_RSTN), .fifo_rd_i(fifo_rd_o), .fifo_wr_i(fifo_wr_o),
		.fifo_data_i(fifo_data_o), .fifo_full_i(fifo_full_i), .core_rstn_i(core_rstn_o),
		.core_stall_i(core_stall_o), .ram_we_i(ram_we_o), .ram_addr_i(ram_addr_o),
		.ram_data_i(ram_data_o), .core_pc_i(core_pc_i), .errors_o(err_total),
		.core_id_i(core_id_o), .timeout_o(timed_out)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			st = lfsr_next(st);
			v = {v[30:0], st[0]};
		end
	endtask

	function automatic logic [31:0] ram_model(input logic [15:0] core, input logic [15:0] addr);
		return {core[7:0], addr ^ 16'hA55A, ~addr[7:0]};
	endfunction

	assign ram_data_i = ram_model(core_id_o, ram_addr_o);

	// Input FIFO with registered output word
	always @(posedge SDK_CLK) begin
		if (SDK_RSTN && fifo_rd_o && in_q.size() > 0) begin
			fifo_data_i <= in_q[0];
			fifo_empty_i <= (in_q.size() == 1);
			void'(in_q.pop_front());
		end
		if (SDK_RSTN && fifo_wr_o) out_q.push_back(fifo_data_o);
		if (SDK_RSTN && ram_we_o != '0) we_seen++;
	end

	// Full stretches of random length
	always @(negedge SDK_CLK) begin
		if (full_left > 0) begin
			full_left--;
		end else begin
			take_bits(full_lfsr, 1, full_bits);
			fifo_full_i = full_bits[0];
			take_bits(full_lfsr, 3, full_bits);
			full_left = full_bits;
		end
	end

	always @(posedge timed_out) begin
		$display("*** FAILED ***");
		$finish;
	end

	task automatic send_frame();
		@(negedge SDK_CLK);
		foreach (frame_q[i]) in_q.push_back(frame_q[i]);
		fifo_empty_i <= 1'b0;
	endtask

	task automatic wait_idle();
		while (in_q.size() != 0) @(negedge SDK_CLK);
		repeat (4) @(negedge SDK_CLK);
	endtask

	task automatic write_cmd(input int core, input int addr, input int nw, input bit hold);
		logic [31:0] w;
		logic [31:0] data[8];
		int base;
		frame_q = '{FLAG_START, 16'(core), CMD_WRITE, 16'(addr), 16'(nw * 4)};
		for (int i = 0; i < nw; i++) begin
			take_bits(stim_lfsr, 32, w);
			data[i] = w;
			frame_q.push_back(w[31:16]);
			frame_q.push_back(w[15:0]);
		end
		base = we_seen;
		if (!hold) begin
			for (int i = 0; i < nw; i++) begin
				chk.expect_write(core, addr, i, data[i]);
			end
		end
		send_frame();
		if (hold) begin
			// Core still running so nothing may reach its RAM
			repeat (HOLD_CYCLES) @(negedge SDK_CLK);
			for (int i = 0; i < nw; i++) chk.expect_write(core, addr, i, data[i]);
			core_pc_i[core*CORE_W +: CORE_W] = CORE_W'(DEF_HALT_PC);
		end
		while (we_seen < base + nw) @(negedge SDK_CLK);
		core_pc_i[core*CORE_W +: CORE_W] = '0;
		wait_idle();
	endtask

	task automatic read_cmd(input int core, input int addr, input int nw);
		int base;
		frame_q = '{FLAG_START, 16'(core), CMD_READ, 16'(addr), 16'(nw * 4)};
		for (int i = 0; i < nw; i++) chk.expect_read(core, addr + i);
		base = out_q.size();
		send_frame();
		while (out_q.size() < base + 2 * nw) @(negedge SDK_CLK);
		wait_idle();
	endtask

	task automatic start_cmd(input int core);
		frame_q = '{FLAG_START, 16'(core), CMD_START};
		chk.expect_start(core);
		send_frame();
		while (core_rstn_o[core]) @(negedge SDK_CLK);
		repeat (DEF_START_HOLD + 4) @(negedge SDK_CLK);
	endtask

	initial begin
		logic [31:0] c;
		logic [31:0] a;
		logic [31:0] n;
		repeat (10) @(posedge SDK_CLK);
		@(negedge SDK_CLK);
		SDK_RSTN = 1'b1;
		chk.check_reset();
		chk.finish_test("reset");
		take_bits(stim_lfsr, 3, c);
		take_bits(stim_lfsr, 12, a);
		take_bits(stim_lfsr, 3, n);
		write_cmd(c, a, n + 1, 1'b0);
		chk.finish_test("write");
		read_cmd(c, a, n + 1);
		chk.finish_test("read");
		take_bits(stim_lfsr, 3, c);
		start_cmd(c);
		chk.finish_test("start");
		@(negedge SDK_CLK);
		core_pc_i[c*CORE_W +: CORE_W] = CORE_W'(DEF_HALT_PC);
		repeat (2) @(negedge SDK_CLK);
		core_pc_i[c*CORE_W +: CORE_W] = '0;
		repeat (2) @(negedge SDK_CLK);
		chk.finish_test("halt");
		take_bits(stim_lfsr, 16, a);
		frame_q = '{(a[15:0] == FLAG_START) ? ~a[15:0] : a[15:0]};
		send_frame();
		wait_idle();
		take_bits(stim_lfsr, 3, c);
		take_bits(stim_lfsr, 12, a);
		take_bits(stim_lfsr, 3, n);
		read_cmd(c, a, n + 1);
		chk.finish_test("bad_frame");
		start_cmd(c);
		take_bits(stim_lfsr, 12, a);
		take_bits(stim_lfsr, 3, n);
		write_cmd(c, a, n + 1, 1'b1);
		chk.finish_test("running_core");
		chk.report_counts();
		if (err_total == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- all.f
hdl/host_link_pkg.sv
hdl/host_cmd_fsm.sv
hdl/ram_xfer_path.sv
hdl/core_ctrl.sv
hdl/host_link_top.sv
tests/host_link_checker.sv
tests/tb_host_link.sv
